// ==== Makefile ====
# Verilator build and run for the IPv4 header editor testbench

TOP := ipv4_edit_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f build.f

# Pass only when the simulation prints the pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

// ==== build.f ====
+incdir+include
hdl/ipv4_edit_pkg.sv
hdl/field_rewriter.sv
hdl/edit_fifo.sv
hdl/checksum_updater.sv
hdl/ipv4_edit_top.sv
test/ipv4_edit_tb.sv

// ==== hdl/checksum_updater.sv ====
// Serial incremental checksum updater

`timescale 1ns/10ps

module checksum_updater (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     not_empty_i,
    input  ipv4_edit_pkg::edit_ent_s head_i,
    output logic                     pop_o,
    output logic                     res_valid_o,
    output ipv4_edit_pkg::edit_res_s res_o
);

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_ADD1 = 2'd1,
        ST_ADD2 = 2'd2,
        ST_ADD3 = 2'd3
    } state_e;

    state_e      state;
    logic [15:0] csum_inv_q;   // ~HC
    logic [15:0] word_inv_q;   // ~m
    logic [15:0] new_word_q;   // m'
    logic        expired_q;
    logic [15:0] sum_q;
    logic [15:0] add_b;
    logic [16:0] sum_raw;
    logic [15:0] add_res;

    assign pop_o = (state == ST_IDLE) && not_empty_i;

    // Operand select for the shared adder
    always_comb begin
        case (state)
            ST_ADD1: add_b = csum_inv_q;
            ST_ADD2: add_b = word_inv_q;
            default: add_b = new_word_q;
        endcase
    end

    // One's-complement add with end-around carry
    assign sum_raw = {1'b0, sum_q} + {1'b0, add_b};
    assign add_res = sum_raw[15:0] + {15'd0, sum_raw[16]};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state       <= ST_IDLE;
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= (state == ST_ADD3);
            case (state)
                ST_IDLE: if (pop_o) state <= ST_ADD1;
                ST_ADD1: state <= ST_ADD2;
                ST_ADD2: state <= ST_ADD3;
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop_o) begin
            csum_inv_q <= ~head_i.old_csum;
            word_inv_q <= ~head_i.old_word;
            new_word_q <= head_i.new_word;
            expired_q  <= head_i.expired;
            sum_q      <= '0;  // Running sum starts empty
        end else if (state != ST_IDLE) begin
            sum_q <= add_res;
        end
        if (state == ST_ADD3) begin
            res_o.new_word <= new_word_q;
            res_o.new_csum <= ~add_res;  // HC' = ~(~HC + ~m + m')
            res_o.expired  <= expired_q;
        end
    end

    // Every pop yields a result strobe four cycles later
    a_pop_to_result: assert property (
        @(posedge clk) disable iff (rst_i)
        pop_o |=> !pop_o [*3] ##1 res_valid_o
    );

endmodule

// ==== hdl/edit_fifo.sv ====
// Edit entry FIFO

`timescale 1ns/10ps

`include "ipv4_edit_cfg.svh"

module edit_fifo (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     wr_i,
    input  ipv4_edit_pkg::edit_ent_s wr_data_i,
    input  logic                     pop_i,
    output ipv4_edit_pkg::edit_ent_s head_o,
    output logic                     not_empty_o,
    output logic                     overflow_o
);

    import ipv4_edit_pkg::*;

    localparam int DEPTH = `IPV4_FIFO_DEPTH;
    localparam int AW    = `IPV4_FIFO_AW;

    edit_ent_s       mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [AW:0]     count;
    logic            full;
    logic            do_wr;
    logic            do_pop;

    assign full        = (count == DEPTH);
    assign not_empty_o = (count != '0);
    assign do_pop      = pop_i && not_empty_o;
    assign do_wr       = wr_i && (!full || do_pop);  // Pop frees a slot this cycle
    assign head_o      = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;  // Wraps at power-of-two depth
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (wr_i && !do_wr) begin
                overflow_o <= 1'b1;  // Sticky until reset
            end
        end
    end

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (rst_i) pop_i |-> not_empty_o
    );

    a_count_bound: assert property (
        @(posedge clk) disable iff (rst_i) count <= DEPTH
    );

endmodule

// ==== hdl/field_rewriter.sv ====
// Header field rewriter

`timescale 1ns/10ps

module field_rewriter (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     req_valid_i,
    input  ipv4_edit_pkg::edit_req_s req_i,
    output logic                     ent_valid_o,
    output ipv4_edit_pkg::edit_ent_s ent_o
);

    import ipv4_edit_pkg::*;

    hdr_word_u new_word;
    logic      expired;

    // Edited word, read through the view that matches the operation
    always_comb begin
        new_word = req_i.old_word;
        expired  = 1'b0;
        case (req_i.op)
            OP_TTL_DEC: begin
                if (req_i.old_word.tp_s.ttl != 8'd0) begin
                    new_word.tp_s.ttl = req_i.old_word.tp_s.ttl - 8'd1;
                end else begin
                    expired = 1'b1;  // Word left as is when TTL is already zero
                end
            end
            OP_TOS_SET: begin
                new_word.vt_s.tos = req_i.arg[7:0];  // Version/IHL byte kept
            end
            OP_WORD_SET: begin
                new_word = req_i.arg;
            end
            default: begin
                new_word = req_i.old_word;  // Unused encoding passes through
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ent_valid_o <= 1'b0;
        end else begin
            ent_valid_o <= req_valid_i;  // FIFO write strobe
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            ent_o.old_csum <= req_i.old_csum;
            ent_o.old_word <= req_i.old_word;
            ent_o.new_word <= new_word;
            ent_o.expired  <= expired;
        end
    end

    // An expired entry must come from a TTL decrement of a zero TTL
    a_expired_ttl_only: assert property (
        @(posedge clk) disable iff (rst_i)
        ent_valid_o && ent_o.expired |->
            $past(req_i.op) == OP_TTL_DEC && $past(req_i.old_word.tp_s.ttl) == 8'd0
    );

endmodule

// ==== hdl/ipv4_edit_pkg.sv ====
// IPv4 editor shared types

package ipv4_edit_pkg;

    // Version/IHL and TOS bytes of header word 0
    typedef struct packed {
        logic [7:0] ver_ihl;
        logic [7:0] tos;
    } ver_tos_s;

    // TTL and protocol bytes of header word 4
    typedef struct packed {
        logic [7:0] ttl;
        logic [7:0] proto;
    } ttl_proto_s;

    typedef union packed {
        ver_tos_s   vt_s;
        ttl_proto_s tp_s;
    } hdr_word_u;

    typedef enum logic [1:0] {
        OP_TTL_DEC  = 2'd0,
        OP_TOS_SET  = 2'd1,
        OP_WORD_SET = 2'd2
    } edit_op_e;

    typedef struct packed {
        edit_op_e    op;
        logic [15:0] old_csum;
        hdr_word_u   old_word;
        logic [15:0] arg;      // New TOS in low byte, or the full new word
    } edit_req_s;

    typedef struct packed {
        logic [15:0] old_csum;
        hdr_word_u   old_word;
        hdr_word_u   new_word;
        logic        expired;
    } edit_ent_s;

    typedef struct packed {
        logic [15:0] new_word;
        logic [15:0] new_csum;
        logic        expired;
    } edit_res_s;

endpackage

// ==== hdl/ipv4_edit_top.sv ====
// IPv4 header editor top level

`timescale 1ns/10ps

module ipv4_edit_top (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     req_valid_i,
    input  ipv4_edit_pkg::edit_req_s req_i,
    output logic                     res_valid_o,
    output ipv4_edit_pkg::edit_res_s res_o,
    output logic                     overflow_o
);

    import ipv4_edit_pkg::*;

    logic      ent_valid;
    edit_ent_s ent;
    logic      pop;
    edit_ent_s head;
    logic      not_empty;

    field_rewriter u_rewriter (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .ent_valid_o (ent_valid),
        .ent_o       (ent)
    );

    edit_fifo u_fifo (
        .clk         (clk),
        .rst_i       (rst_i),
        .wr_i        (ent_valid),
        .wr_data_i   (ent),
        .pop_i       (pop),
        .head_o      (head),
        .not_empty_o (not_empty),
        .overflow_o  (overflow_o)
    );

    checksum_updater u_updater (
        .clk         (clk),
        .rst_i       (rst_i),
        .not_empty_i (not_empty),
        .head_i      (head),
        .pop_o       (pop),
        .res_valid_o (res_valid_o),
        .res_o       (res_o)
    );

endmodule

// ==== include/ipv4_edit_cfg.svh ====
// IPv4 editor configuration

`ifndef IPV4_EDIT_CFG_SVH
`define IPV4_EDIT_CFG_SVH

// Number of queued edits between rewriter and checksum updater
// Must be a power of two
`define IPV4_FIFO_DEPTH 8

// Pointer width, log2 of the depth
`define IPV4_FIFO_AW 3

`endif

// ==== test/ipv4_edit_tb.sv ====
// IPv4 header editor testbench

`timescale 1ns/10ps

module ipv4_edit_tb;

    import ipv4_edit_pkg::*;

    localparam int TOTAL_REQ       = 86;                     // Requests over all tests
    localparam int WATCHDOG_CYCLES = 16 + 200 * TOTAL_REQ + 500;

    logic      clk;
    logic      rst_i;
    logic      req_valid_i;
    edit_req_s req_i;
    logic      res_valid_o;
    edit_res_s res_o;
    logic      overflow_o;

    integer    seed;
    int        n_pass;
    int        n_fail;
    int        n_results;
    bit        skip_dropped;                                 // Set while requests may be lost
    edit_res_s exp_q[$];
    edit_res_s exp_res;

    ipv4_edit_top u_ipv4_edit_top (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .res_valid_o (res_valid_o),
        .res_o       (res_o),
        .overflow_o  (overflow_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                               // 8 ns period
    end

    // Reference model applying the field rules and HC' = ~(~HC + ~m + m')
    function automatic edit_res_s expected_result(input edit_req_s r);
        logic [15:0] w;
        logic [31:0] s;
        edit_res_s   e;
        w          = r.old_word;
        e.expired  = 1'b0;
        e.new_word = w;
        if (r.op == OP_TTL_DEC) begin
            if (w[15:8] == 8'h00) begin
                e.expired = 1'b1;
            end else begin
                e.new_word = w - 16'h0100;                   // TTL is the high byte
            end
        end else if (r.op == OP_TOS_SET) begin
            e.new_word = {w[15:8], r.arg[7:0]};
        end else if (r.op == OP_WORD_SET) begin
            e.new_word = r.arg;
        end
        s = {16'h0, ~r.old_csum} + {16'h0, ~w} + {16'h0, e.new_word};
        s = {16'h0, s[15:0]} + {16'h0, s[31:16]};           // Fold carries back in
        s = {16'h0, s[15:0]} + {16'h0, s[31:16]};
        e.new_csum = ~s[15:0];
        return e;
    endfunction

    function automatic logic [15:0] rand16();
        logic [31:0] r;
        r = $random(seed);
        return r[15:0];
    endfunction

    function automatic edit_op_e rand_op();
        logic [31:0] r;
        r = $random(seed);
        case (r[1:0])
            2'd1:    return OP_TOS_SET;
            2'd2:    return OP_WORD_SET;
            default: return OP_TTL_DEC;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [15:0] exp,
                             input logic [15:0] got);
        if (got !== exp) begin
            $display("error %s exp %h got %h", name, exp, got);
            n_fail++;
        end else begin
            n_pass++;
        end
    endtask

    // Result monitor comparing against the oldest pending expectation
    always @(negedge clk) begin
        if (!rst_i && res_valid_o) begin
            n_results++;
            if (skip_dropped) begin
                while (exp_q.size() > 0 && exp_q[0] != res_o) begin
                    exp_q.delete(0);                         // Lost to the full FIFO
                end
            end
            if (exp_q.size() == 0) begin
                $display("result %h arrived with no matching request pending", res_o);
                n_fail++;
            end else begin
                exp_res = exp_q.pop_front();
                check_val("new_word", exp_res.new_word, res_o.new_word);
                check_val("new_csum", exp_res.new_csum, res_o.new_csum);
                check_val("expired", {15'h0, exp_res.expired}, {15'h0, res_o.expired});
            end
        end
    end

    task automatic issue(input edit_op_e op, input logic [15:0] csum,
                         input logic [15:0] word, input logic [15:0] arg);
        edit_req_s r;
        r.op       = op;
        r.old_csum = csum;
        r.old_word = word;
        r.arg      = arg;
        @(posedge clk);
        req_valid_i <= 1'b1;
        req_i       <= r;
        exp_q.push_back(expected_result(r));
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            req_valid_i <= 1'b0;
        end
    endtask

    // Waits for every pending result, or for a quiet DUT when drops are allowed
    task automatic wait_results(input int max_cycles);
        int waited;
        int quiet;
        waited = 0;
        quiet  = 0;
        while (exp_q.size() > 0 && !(skip_dropped && quiet >= 16)) begin
            @(negedge clk);
            waited++;
            quiet = res_valid_o ? 0 : quiet + 1;
            if (waited >= max_cycles) begin
                $display("%0d results still missing after %0d cycles", exp_q.size(), waited);
                n_fail++;
                break;
            end
        end
        exp_q.delete();
    endtask

    task automatic report(input string name, input int errs_before);
        $display("test %s done, %0d errors", name, n_fail - errs_before);
    endtask

    task automatic test_rfc_example();
        int errs;
        edit_res_s lit;
        errs         = n_fail;
        lit.new_word = 16'h3285;
        lit.new_csum = 16'h0000;
        lit.expired  = 1'b0;
        issue(OP_WORD_SET, 16'hdd2f, 16'h5555, 16'h3285);
        exp_q.delete(exp_q.size() - 1);
        exp_q.push_back(lit);                                // Known answer from RFC 1624
        idle(1);
        wait_results(100);
        report("rfc1624_example", errs);
    endtask

    task automatic test_ttl_dec();
        int          errs;
        int          i;
        logic [15:0] w;
        errs = n_fail;
        for (i = 0; i < 8; i++) begin
            w = rand16();
            if (w[15:8] == 8'h00) begin
                w[15:8] = 8'h01;
            end
            issue(OP_TTL_DEC, rand16(), w, rand16());
            idle(4);
        end
        w       = rand16();
        w[15:8] = 8'h00;                                     // Expired packet
        issue(OP_TTL_DEC, rand16(), w, rand16());
        idle(1);
        wait_results(200);
        report("ttl_dec", errs);
    endtask

    task automatic test_tos_set();
        int errs;
        int i;
        errs = n_fail;
        for (i = 0; i < 8; i++) begin
            issue(OP_TOS_SET, rand16(), rand16(), rand16());
            idle(4);
        end
        wait_results(200);
        report("tos_set", errs);
    endtask

    task automatic test_ordering();
        int errs;
        int i;
        errs = n_fail;
        for (i = 0; i < 20; i++) begin
            issue(rand_op(), rand16(), rand16(), rand16());
            idle(3 + rand16() % 4);                          // Spacing of 4 to 7 cycles
        end
        wait_results(400);
        check_val("overflow_o", 16'h0, {15'h0, overflow_o});
        report("ordering", errs);
    endtask

    task automatic test_burst();
        int errs;
        int i;
        errs = n_fail;
        for (i = 0; i < 8; i++) begin
            issue(rand_op(), rand16(), rand16(), rand16());
        end
        idle(1);
        wait_results(200);
        check_val("overflow_o", 16'h0, {15'h0, overflow_o});
        report("burst", errs);
    endtask

    task automatic test_overflow();
        int errs;
        int i;
        int start;
        errs         = n_fail;
        start        = n_results;
        skip_dropped = 1'b1;
        for (i = 0; i < 40; i++) begin
            issue(rand_op(), rand16(), rand16(), rand16());
        end
        idle(1);
        wait_results(1000);
        skip_dropped = 1'b0;
        check_val("overflow_o", 16'h1, {15'h0, overflow_o});
        if (n_results - start >= 40) begin
            $display("all 40 results arrived although the FIFO should have dropped some");
            n_fail++;
        end
        report("overflow", errs);
    endtask

    initial begin
        seed         = 32'h1fbd;
        n_pass       = 0;
        n_fail       = 0;
        n_results    = 0;
        skip_dropped = 1'b0;
        rst_i        = 1'b1;
        req_valid_i  = 1'b0;
        req_i        = '0;
        repeat (16) @(posedge clk);
        rst_i <= 1'b0;
        idle(2);
        test_rfc_example();
        test_ttl_dec();
        test_tos_set();
        test_ordering();
        test_burst();
        test_overflow();                                     // Runs last as the flag is sticky
        $display("checks passed %0d failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

endmodule
